// File: Bender.yml
package:
  name: vid_switch

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vid_switch_pkg.sv
      - verilog/stream_input.sv
      - verilog/packet_switch.sv
      - verilog/vid_switch.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_vid_switch.sv

// File: tests/tb_vid_switch.sv
`include "vid_switch_config.svh"

module tb_vid_switch
    import vid_switch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW = `VS_DATA_WIDTH;
    localparam int WAIT_LIMIT = 200;

    logic          clk = 1'b0;
    logic          rst;
    logic          cmd_valid;
    sw_cmd_t       cmd;
    sw_cmd_t       cur_cmd;
    logic          cmd_done;
    logic          din0_ready;
    logic          din0_valid;
    logic [DW-1:0] din0_data;
    logic          din0_sop;
    logic          din0_eop;
    logic          din1_ready;
    logic          din1_valid;
    logic [DW-1:0] din1_data;
    logic          din1_sop;
    logic          din1_eop;
    logic          dout_ready;
    logic          dout_valid;
    logic [DW-1:0] dout_data;
    logic          dout_sop;
    logic          dout_eop;

    logic [15:0]   lfsr = 16'd50045;
    // din_ready of the previous cycle, which gates the sources
    logic [1:0]    ready_q = 2'b00;
    logic          dout_ready_q = 1'b0;
    logic          din1_quiet = 1'b0;
    logic          rand_done = 1'b0;
    int            cyc = 0;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            start_errors = 0;

    // scoreboard, {sop, eop, data} and the cycle the beat is due (-1 when free)
    logic [DW+1:0] exp_beats[$];
    int            exp_cycles[$];

    vid_switch dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cur_cmd    (cur_cmd),
        .cmd_done   (cmd_done),
        .din0_ready (din0_ready),
        .din0_valid (din0_valid),
        .din0_data  (din0_data),
        .din0_sop   (din0_sop),
        .din0_eop   (din0_eop),
        .din1_ready (din1_ready),
        .din1_valid (din1_valid),
        .din1_data  (din1_data),
        .din1_sop   (din1_sop),
        .din1_eop   (din1_eop),
        .dout_ready (dout_ready),
        .dout_valid (dout_valid),
        .dout_data  (dout_data),
        .dout_sop   (dout_sop),
        .dout_eop   (dout_eop)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc          <= cyc + 1;
        ready_q      <= {din1_ready, din0_ready};
        dout_ready_q <= dout_ready;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        errors++;
        finish_run();
    endtask

    // output monitor, compares every dout beat against the scoreboard
    always @(posedge clk) begin : monitor
        logic [DW+1:0] want;
        int            due;
        if (!rst) begin
            if (dout_valid && !dout_ready_q) begin
                $display("dout_valid high at %0d ns after a cycle with dout_ready low", $time);
                errors++;
            end
            if (dout_valid) begin
                if (exp_beats.size() == 0) begin
                    $display("unexpected beat %h on dout at %0d ns", dout_data, $time);
                    errors++;
                end else begin
                    want = exp_beats.pop_front();
                    due  = exp_cycles.pop_front();
                    check_value("dout_data", dout_data, want[DW-1:0]);
                    check_value("dout_sop", dout_sop, want[DW+1]);
                    check_value("dout_eop", dout_eop, want[DW]);
                    if (due >= 0) begin
                        check_value("dout beat cycle", cyc, due);
                    end
                end
            end
            if (din1_quiet) begin
                check_value("din1_ready", din1_ready, 1'b0);
            end
        end
    end

    task automatic drive_port(input int port, input logic valid, input logic [DW-1:0] data,
                              input logic sop, input logic eop);
        if (port == 0) begin
            din0_valid = valid;
            din0_data  = data;
            din0_sop   = sop;
            din0_eop   = eop;
        end else begin
            din1_valid = valid;
            din1_data  = data;
            din1_sop   = sop;
            din1_eop   = eop;
        end
    endtask

    // stray packets carry no sop and are not expected on dout
    task automatic send_packet(input int port, input int len, input logic [7:0] tag,
                               input logic stray, input logic timed);
        logic [DW-1:0] data;
        logic          sop;
        logic          eop;
        int            waited;
        for (int i = 0; i < len; i++) begin
            data   = {tag, 16'(i)};
            sop    = !stray && (i == 0);
            eop    = (i == len - 1);
            waited = 0;
            @(negedge clk);
            while (!ready_q[port]) begin
                drive_port(port, 1'b0, '0, 1'b0, 1'b0);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    timeout_abort($sformatf("din%0d_ready stayed low", port));
                end
                @(negedge clk);
            end
            drive_port(port, 1'b1, data, sop, eop);
            if (!stray) begin
                exp_beats.push_back({sop, eop, data});
                exp_cycles.push_back(timed ? cyc + 2 : -1);
            end
        end
        @(negedge clk);
        drive_port(port, 1'b0, '0, 1'b0, 1'b0);
    endtask

    // a source that sends only when granted, no beat of it may reach dout
    task automatic offer_blocked(input int port, input int cycles, input logic [7:0] tag);
        int sent;
        sent = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (ready_q[port]) begin
                drive_port(port, 1'b1, {tag, 16'(sent)}, sent == 0, 1'b0);
                sent++;
            end else begin
                drive_port(port, 1'b0, '0, 1'b0, 1'b0);
            end
        end
        @(negedge clk);
        drive_port(port, 1'b0, '0, 1'b0, 1'b0);
        check_value($sformatf("din%0d beats granted", port), sent, 0);
    endtask

    task automatic issue_cmd(input sw_cmd_t c);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = c;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_cmd_done(input sw_cmd_t want);
        int waited;
        waited = 0;
        while (!cmd_done) begin
            waited++;
            if (waited > 10) begin
                timeout_abort("cmd_done never pulsed");
            end
            @(negedge clk);
        end
        check_value("cur_cmd", cur_cmd, want);
        @(negedge clk);
        check_value("cmd_done", cmd_done, 1'b0);
    endtask

    // all expected beats out, then a short window to catch extras
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_beats.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_abort("expected beats never reached dout");
            end
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic quiet_window(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("din0_ready", din0_ready, 1'b0);
            check_value("din1_ready", din1_ready, 1'b0);
            check_value("dout_valid", dout_valid, 1'b0);
        end
    endtask

    task automatic test_start();
        tests_run++;
        start_errors = errors;
    endtask

    task automatic test_end(input string name);
        if (errors == start_errors) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset_state();
        test_start();
        check_value("din0_ready", din0_ready, 1'b0);
        check_value("din1_ready", din1_ready, 1'b0);
        check_value("dout_valid", dout_valid, 1'b0);
        check_value("cmd_done", cmd_done, 1'b0);
        check_value("cur_cmd", cur_cmd, `VS_RESET_CMD);
        // a packet waits at din0, the disabled switch never grants it
        fork
            quiet_window(20);
            offer_blocked(0, 20, 8'h0a);
        join
        test_end("reset and disabled state");
    endtask

    task automatic test_select_port0();
        test_start();
        issue_cmd(CMD_SELECT_0);
        wait_cmd_done(CMD_SELECT_0);
        din1_quiet = 1'b1;
        send_packet(0, 6, 8'h10, 1'b0, 1'b1);
        wait_drain();
        din1_quiet = 1'b0;
        test_end("select port 0");
    endtask

    task automatic test_switch_mid_packet();
        int waited;
        test_start();
        fork
            send_packet(0, 10, 8'h20, 1'b0, 1'b0);
            begin
                repeat (3) @(negedge clk);
                issue_cmd(CMD_SELECT_1);
                waited = 0;
                while (cur_cmd != CMD_SELECT_1) begin
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        timeout_abort("cur_cmd never changed to port 1");
                    end
                    @(negedge clk);
                end
                // the whole port 0 packet must be out before the switch
                check_value("port 0 beats left at switch", exp_beats.size(), 0);
            end
        join
        send_packet(1, 5, 8'h30, 1'b0, 1'b1);
        wait_drain();
        test_end("switch in mid packet");
    endtask

    task automatic test_stray_beats();
        test_start();
        send_packet(1, 3, 8'h40, 1'b1, 1'b0);
        send_packet(1, 4, 8'h50, 1'b0, 1'b1);
        wait_drain();
        test_end("stray beats dropped");
    endtask

    task automatic test_random_ready();
        test_start();
        rand_done = 1'b0;
        fork
            begin
                send_packet(1, 48, 8'h60, 1'b0, 1'b0);
                wait_drain();
                rand_done = 1'b1;
            end
            while (!rand_done) begin
                @(negedge clk);
                dout_ready = lfsr_bit();
            end
        join
        @(negedge clk);
        dout_ready = 1'b1;
        test_end("random back-pressure");
    endtask

    task automatic test_disable();
        int waited;
        test_start();
        issue_cmd(CMD_DISABLE);
        waited = 0;
        while ((din0_ready || din1_ready) && waited < 2) begin
            @(negedge clk);
            waited++;
        end
        check_value("din0_ready", din0_ready, 1'b0);
        check_value("din1_ready", din1_ready, 1'b0);
        check_value("cur_cmd", cur_cmd, CMD_DISABLE);
        // both sources keep offering, nothing may come through
        fork
            quiet_window(20);
            offer_blocked(0, 20, 8'h70);
            offer_blocked(1, 20, 8'h71);
        join
        test_end("disable output");
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = CMD_DISABLE;
        drive_port(0, 1'b0, '0, 1'b0, 1'b0);
        drive_port(1, 1'b0, '0, 1'b0, 1'b0);
        dout_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_select_port0();
        test_switch_mid_packet();
        test_stray_beats();
        test_random_ready();
        test_disable();
        finish_run();
    end

endmodule

// File: verilog/packet_switch.sv
`include "vid_switch_config.svh"

module packet_switch
    import vid_switch_pkg::*;
#(
    parameter int DATA_WIDTH = 24
) (
    input  logic                  clk,
    input  logic                  rst,

    // command strobe and status
    input  logic                  cmd_valid,
    input  sw_cmd_t               cmd,
    output sw_cmd_t               cur_cmd,
    output logic                  cmd_done,

    // internal stream from port 0
    output logic                  int0_ready,
    input  logic                  int0_valid,
    input  logic [DATA_WIDTH-1:0] int0_data,
    input  logic                  int0_sop,
    input  logic                  int0_eop,

    // internal stream from port 1
    output logic                  int1_ready,
    input  logic                  int1_valid,
    input  logic [DATA_WIDTH-1:0] int1_data,
    input  logic                  int1_sop,
    input  logic                  int1_eop,

    // output stream, ready latency 1
    input  logic                  dout_ready,
    output logic                  dout_valid,
    output logic [DATA_WIDTH-1:0] dout_data,
    output logic                  dout_sop,
    output logic                  dout_eop
);

    // command waiting for the next packet boundary
    logic                  pend_valid;
    sw_cmd_t               pend_cmd;

    // command steering the mux in this cycle
    sw_cmd_t               cmd_eff;
    logic                  apply;

    sw_state_t             state;
    sw_state_t             state_next;

    // selected internal stream
    logic                  sel_valid;
    logic [DATA_WIDTH-1:0] sel_data;
    logic                  sel_sop;
    logic                  sel_eop;
    logic                  sel_ready;

    logic                  take;
    logic                  fwd;

    // commands only switch between packets
    assign apply   = (state == SW_IDLE) && pend_valid;
    assign cmd_eff = apply ? pend_cmd : cur_cmd;

    // a new strobe overwrites whatever is still pending
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
            pend_cmd   <= `VS_RESET_CMD;
        end else if (cmd_valid) begin
            pend_valid <= 1'b1;
            pend_cmd   <= cmd;
        end else if (apply) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_cmd  <= `VS_RESET_CMD;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= apply;
            if (apply) begin
                cur_cmd <= pend_cmd;
            end
        end
    end

    // input selection
    always_comb begin
        case (cmd_eff)
            CMD_SELECT_0: begin
                sel_valid = int0_valid;
                sel_data  = int0_data;
                sel_sop   = int0_sop;
                sel_eop   = int0_eop;
            end
            CMD_SELECT_1: begin
                sel_valid = int1_valid;
                sel_data  = int1_data;
                sel_sop   = int1_sop;
                sel_eop   = int1_eop;
            end
            default: begin
                sel_valid = 1'b0;
                sel_data  = '0;
                sel_sop   = 1'b0;
                sel_eop   = 1'b0;
            end
        endcase
    end

    // unselected port is stalled, selected port follows the sink
    assign int0_ready = (cmd_eff == CMD_SELECT_0) && dout_ready;
    assign int1_ready = (cmd_eff == CMD_SELECT_1) && dout_ready;
    assign sel_ready  = int0_ready || int1_ready;

    assign take = sel_valid && sel_ready;

    // outside a packet only a sop beat gets through, stray beats are dropped
    assign fwd = take && ((state == SW_PASS) || sel_sop);

    always_comb begin
        state_next = state;
        case (state)
            SW_IDLE: begin
                // single-beat packet leaves us idle
                if (take && sel_sop && !sel_eop) begin
                    state_next = SW_PASS;
                end
            end
            SW_PASS: begin
                if (take && sel_eop) begin
                    state_next = SW_IDLE;
                end
            end
            default: begin
                state_next = SW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SW_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // output register
    // a beat is only taken when dout_ready was high, so the next cycle
    // meets the ready latency of the sink
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            dout_data <= sel_data;
            dout_sop  <= sel_sop;
            dout_eop  <= sel_eop;
        end
    end

endmodule

// File: verilog/stream_input.sv
module stream_input #(
    parameter int DATA_WIDTH = 24
) (
    input  logic                  clk,
    input  logic                  rst,

    // external stream, ready latency 1
    output logic                  din_ready,
    input  logic                  din_valid,
    input  logic [DATA_WIDTH-1:0] din_data,
    input  logic                  din_sop,
    input  logic                  din_eop,

    // internal stream, ready latency 0
    input  logic                  int_ready,
    output logic                  int_valid,
    output logic [DATA_WIDTH-1:0] int_data,
    output logic                  int_sop,
    output logic                  int_eop
);

    // first stage, din delayed by one cycle
    logic                  reg_valid;
    logic [DATA_WIDTH-1:0] reg_data;
    logic                  reg_sop;
    logic                  reg_eop;

    // second stage
    logic                  buf1_valid;
    logic [DATA_WIDTH-1:0] buf1_data;
    logic                  buf1_sop;
    logic                  buf1_eop;

    // third stage
    logic                  buf2_valid;
    logic [DATA_WIDTH-1:0] buf2_data;
    logic                  buf2_sop;
    logic                  buf2_eop;

    // int_ready delayed once and twice
    logic                  ready_d1;
    logic                  ready_d2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_d1 <= 1'b0;
            ready_d2 <= 1'b0;
        end else begin
            ready_d1 <= int_ready;
            ready_d2 <= ready_d1;
        end
    end

    // registered ready toward the source
    assign din_ready = ready_d1;

    // valid bits of the shift chain
    // the chain only moves while beats can still be arriving
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_valid  <= 1'b0;
            buf1_valid <= 1'b0;
            buf2_valid <= 1'b0;
        end else if (ready_d2) begin
            reg_valid  <= din_valid;
            buf1_valid <= reg_valid;
            buf2_valid <= buf1_valid;
        end
    end

    // beat payload follows the same shift
    always_ff @(posedge clk) begin
        if (ready_d2) begin
            reg_data  <= din_data;
            reg_sop   <= din_sop;
            reg_eop   <= din_eop;
            buf1_data <= reg_data;
            buf1_sop  <= reg_sop;
            buf1_eop  <= reg_eop;
            buf2_data <= buf1_data;
            buf2_sop  <= buf1_sop;
            buf2_eop  <= buf1_eop;
        end
    end

    // pick the oldest beat not yet handed on
    // both delays high: chain is flowing, reg holds the next beat
    // one delay high: ready just changed, buf1 holds it
    // both low: chain frozen, buf2 holds the oldest waiting beat
    always_comb begin
        case ({ready_d2, ready_d1})
            2'b11: begin
                int_valid = reg_valid;
                int_data  = reg_data;
                int_sop   = reg_sop;
                int_eop   = reg_eop;
            end
            2'b10, 2'b01: begin
                int_valid = buf1_valid;
                int_data  = buf1_data;
                int_sop   = buf1_sop;
                int_eop   = buf1_eop;
            end
            default: begin
                int_valid = buf2_valid;
                int_data  = buf2_data;
                int_sop   = buf2_sop;
                int_eop   = buf2_eop;
            end
        endcase
    end

endmodule

// File: verilog/vid_switch.sv
`include "vid_switch_config.svh"

module vid_switch
    import vid_switch_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // switch control
    input  logic                      cmd_valid,
    input  sw_cmd_t                   cmd,
    output sw_cmd_t                   cur_cmd,
    output logic                      cmd_done,

    // input port 0
    output logic                      din0_ready,
    input  logic                      din0_valid,
    input  logic [`VS_DATA_WIDTH-1:0] din0_data,
    input  logic                      din0_sop,
    input  logic                      din0_eop,

    // input port 1
    output logic                      din1_ready,
    input  logic                      din1_valid,
    input  logic [`VS_DATA_WIDTH-1:0] din1_data,
    input  logic                      din1_sop,
    input  logic                      din1_eop,

    // output port
    input  logic                      dout_ready,
    output logic                      dout_valid,
    output logic [`VS_DATA_WIDTH-1:0] dout_data,
    output logic                      dout_sop,
    output logic                      dout_eop
);

    // adapter to core streams
    logic                      int0_ready;
    logic                      int0_valid;
    logic [`VS_DATA_WIDTH-1:0] int0_data;
    logic                      int0_sop;
    logic                      int0_eop;

    logic                      int1_ready;
    logic                      int1_valid;
    logic [`VS_DATA_WIDTH-1:0] int1_data;
    logic                      int1_sop;
    logic                      int1_eop;

    stream_input #(
        .DATA_WIDTH(`VS_DATA_WIDTH)
    ) u_in0 (
        .clk       (clk),
        .rst       (rst),
        .din_ready (din0_ready),
        .din_valid (din0_valid),
        .din_data  (din0_data),
        .din_sop   (din0_sop),
        .din_eop   (din0_eop),
        .int_ready (int0_ready),
        .int_valid (int0_valid),
        .int_data  (int0_data),
        .int_sop   (int0_sop),
        .int_eop   (int0_eop)
    );

    stream_input #(
        .DATA_WIDTH(`VS_DATA_WIDTH)
    ) u_in1 (
        .clk       (clk),
        .rst       (rst),
        .din_ready (din1_ready),
        .din_valid (din1_valid),
        .din_data  (din1_data),
        .din_sop   (din1_sop),
        .din_eop   (din1_eop),
        .int_ready (int1_ready),
        .int_valid (int1_valid),
        .int_data  (int1_data),
        .int_sop   (int1_sop),
        .int_eop   (int1_eop)
    );

    packet_switch #(
        .DATA_WIDTH(`VS_DATA_WIDTH)
    ) u_switch (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cur_cmd    (cur_cmd),
        .cmd_done   (cmd_done),
        .int0_ready (int0_ready),
        .int0_valid (int0_valid),
        .int0_data  (int0_data),
        .int0_sop   (int0_sop),
        .int0_eop   (int0_eop),
        .int1_ready (int1_ready),
        .int1_valid (int1_valid),
        .int1_data  (int1_data),
        .int1_sop   (int1_sop),
        .int1_eop   (int1_eop),
        .dout_ready (dout_ready),
        .dout_valid (dout_valid),
        .dout_data  (dout_data),
        .dout_sop   (dout_sop),
        .dout_eop   (dout_eop)
    );

endmodule

// File: verilog/vid_switch_config.svh
`ifndef VID_SWITCH_CONFIG_SVH
`define VID_SWITCH_CONFIG_SVH

// beat width, three 8-bit colour samples per pixel
`define VS_DATA_WIDTH 24

// command in force after reset
// the output stays off until a port is selected
`define VS_RESET_CMD vid_switch_pkg::CMD_DISABLE

`endif

// File: verilog/vid_switch_pkg.sv
package vid_switch_pkg;

    // commands accepted on the cmd strobe
    typedef enum logic [1:0] {
        CMD_SELECT_0 = 2'd0,
        CMD_SELECT_1 = 2'd1,
        CMD_DISABLE  = 2'd2
    } sw_cmd_t;

    // switch core position relative to packet boundaries
    typedef enum logic {
        SW_IDLE = 1'b0,
        SW_PASS = 1'b1
    } sw_state_t;

endpackage

// File: vlog.f
+incdir+verilog
verilog/vid_switch_pkg.sv
verilog/stream_input.sv
verilog/packet_switch.sv
verilog/vid_switch.sv
tests/tb_vid_switch.sv
